// File: hw/mem_channel_defines.svh
/*
 * sizes shared by the memory channel RTL and its testbench
 * MC_LINE_W must be a power-of-two multiple of MC_DATA_W
 * MC_CHAN_ADDR_W must equal log2(MC_LINES * MC_LINE_W / 8)
 * any address bit at or above MC_CHAN_ADDR_W makes a request fail with SLVERR
 */
`ifndef MEM_CHANNEL_DEFINES_SVH
`define MEM_CHANNEL_DEFINES_SVH

`define MC_ADDR_W       32   // AXI4-Lite byte address
`define MC_DATA_W       32   // AXI4-Lite word

// line memory geometry
`define MC_LINE_W       128
`define MC_LINES        64
`define MC_CHAN_ADDR_W  10   // 64 lines of 16 bytes

// entries in each of the request and response FIFOs
`define MC_FIFO_DEPTH   4

`endif

// File: hw/mem_channel_pkg.sv
/*
 * request and response payloads carried between the AXI4-Lite port and the
 * line store through the two FIFOs
 * only OKAY and SLVERR are ever produced, there is no EXOKAY or DECERR
 * field widths follow mem_channel_defines.svh
 */
`default_nettype none

`include "mem_channel_defines.svh"

package mem_channel_pkg;

    // AXI response code, encoded as on the bus
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // one narrow access, as accepted from the AW+W or AR channel
    typedef struct packed {
        logic                       write;
        logic [`MC_ADDR_W-1:0]      addr;   // byte address
        logic [`MC_DATA_W-1:0]      wdata;
        logic [`MC_DATA_W/8-1:0]    wstrb;  // zero for reads
    } mem_req_t;

    // one completion, steered to B or R by the write flag
    typedef struct packed {
        logic                       write;
        axi_resp_e                  resp;
        logic [`MC_DATA_W-1:0]      rdata;  // zero for writes and errors
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
/*
 * single-clock FIFO for any packed payload type
 * push while full is taken only together with a pop in the same cycle
 * pop while empty is ignored
 * the head is visible on pop_data without a read cycle
 */
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clock_i,
    input  logic     reset_ni,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_push;
    logic                do_pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);   // slot frees up at the same edge

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/axil_slave_port.sv
/*
 * AXI4-Lite slave front end, no protection signals
 * a write needs AW and W valid in the same cycle, both are taken together
 * writes win over reads when both are offered
 * ready outputs depend combinationally on valid and on the request FIFO
 * B and R beats come straight from the head of the response FIFO
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_channel_defines.svh"

module axil_slave_port (
    input  logic                          clock_i,
    input  logic                          reset_ni,

    // write address and data
    input  logic [`MC_ADDR_W-1:0]         awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`MC_DATA_W-1:0]         wdata,
    input  logic [`MC_DATA_W/8-1:0]       wstrb,
    input  logic                          wvalid,
    output logic                          wready,

    // write response
    output mem_channel_pkg::axi_resp_e    bresp,
    output logic                          bvalid,
    input  logic                          bready,

    // read address and data
    input  logic [`MC_ADDR_W-1:0]         araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`MC_DATA_W-1:0]         rdata,
    output mem_channel_pkg::axi_resp_e    rresp,
    output logic                          rvalid,
    input  logic                          rready,

    // request FIFO write side
    output logic                          req_push,
    output mem_channel_pkg::mem_req_t     req_data,
    input  logic                          req_full,

    // response FIFO read side
    input  mem_channel_pkg::mem_rsp_t     rsp_data,
    input  logic                          rsp_empty,
    output logic                          rsp_pop
);

    logic accept_en;    // request path opens one cycle after reset release
    logic wr_accept;
    logic rd_accept;

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            accept_en <= 1'b0;
        end else begin
            accept_en <= 1'b1;
        end
    end

    // write has priority, a read only goes when no write is taken
    assign wr_accept = accept_en & awvalid & wvalid & ~req_full;
    assign rd_accept = accept_en & arvalid & ~req_full & ~wr_accept;

    assign awready  = wr_accept;
    assign wready   = wr_accept;   // AW and W always handshake together
    assign arready  = rd_accept;
    assign req_push = wr_accept | rd_accept;

    always_comb begin
        req_data.write = wr_accept;
        if (wr_accept) begin
            req_data.addr  = awaddr;
            req_data.wdata = wdata;
            req_data.wstrb = wstrb;
        end else begin
            req_data.addr  = araddr;
            req_data.wdata = '0;
            req_data.wstrb = '0;   // reads never touch the line
        end
    end

    // head of the response FIFO goes out on B or R
    assign bvalid = ~rsp_empty & rsp_data.write;
    assign rvalid = ~rsp_empty & ~rsp_data.write;
    assign bresp  = rsp_data.resp;
    assign rresp  = rsp_data.resp;
    assign rdata  = rsp_data.rdata;

    // only one of bvalid and rvalid is high at a time
    assign rsp_pop = (bvalid & bready) | (rvalid & rready);

endmodule

`default_nettype wire

// File: hw/line_store.sv
/*
 * wide line memory behind the request FIFO
 * each narrow word maps to one lane of a line, the byte strobe is widened
 * to a line strobe so the other lanes are left as they were
 * address bits at or above MC_CHAN_ADDR_W must be zero, otherwise the
 * access is refused with SLVERR and zero data and the memory is untouched
 * no pop in a cycle that pushes a response, so at most one every other cycle
 * line contents are undefined until written
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_channel_defines.svh"

module line_store (
    input  logic                         clock_i,
    input  logic                         reset_ni,
    input  mem_channel_pkg::mem_req_t    req_data,
    input  logic                         req_empty,
    output logic                         req_pop,
    input  logic                         rsp_full,
    output logic                         rsp_push,
    output mem_channel_pkg::mem_rsp_t    rsp_data
);

    localparam int LANES   = `MC_LINE_W / `MC_DATA_W;
    localparam int LANE_W  = $clog2(LANES);
    localparam int OFF_W   = $clog2(`MC_DATA_W / 8);   // byte offset in a word
    localparam int IDX_W   = $clog2(`MC_LINES);
    localparam int LBYTES  = `MC_LINE_W / 8;

    logic [`MC_LINE_W-1:0]   mem [`MC_LINES];

    logic [IDX_W-1:0]        line_idx;
    logic [LANE_W-1:0]       lane;
    logic                    in_range;
    logic [LBYTES-1:0]       line_strb;
    logic [`MC_LINE_W-1:0]   line_wdata;
    logic [`MC_LINE_W-1:0]   line_rd;

    // the pending response still needs a slot in the response FIFO
    assign req_pop = ~req_empty & ~rsp_full & ~rsp_push;

    // byte address = {upper, line index, lane, byte offset}
    assign lane     = req_data.addr[OFF_W +: LANE_W];
    assign line_idx = req_data.addr[OFF_W + LANE_W +: IDX_W];
    assign in_range = ~|req_data.addr[`MC_ADDR_W-1:`MC_CHAN_ADDR_W];

    // word copied to every lane, strobe shifted into the addressed one
    assign line_wdata = {LANES{req_data.wdata}};
    assign line_strb  = LBYTES'(req_data.wstrb) << (lane * (`MC_DATA_W / 8));
    assign line_rd    = mem[line_idx];

    always_ff @(posedge clock_i) begin
        if (req_pop && req_data.write && in_range) begin
            for (int b = 0; b < LBYTES; b++) begin
                if (line_strb[b]) begin
                    mem[line_idx][b*8 +: 8] <= line_wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock_i or negedge reset_ni) begin
        if (!reset_ni) begin
            rsp_push <= 1'b0;
        end else begin
            rsp_push <= req_pop;   // one response per pop a cycle later
        end
    end

    // response payload is valid only while rsp_push is high
    always_ff @(posedge clock_i) begin
        if (req_pop) begin
            rsp_data.write <= req_data.write;
            rsp_data.resp  <= in_range ? mem_channel_pkg::OKAY : mem_channel_pkg::SLVERR;
            if (in_range && !req_data.write) begin
                rsp_data.rdata <= line_rd[lane * `MC_DATA_W +: `MC_DATA_W];
            end else begin
                rsp_data.rdata <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_channel.sv
/*
 * one memory channel with an AXI4-Lite slave port
 * requests and responses are buffered in two FIFOs of MC_FIFO_DEPTH entries
 * responses return in request order, at least 3 cycles after acceptance
 * single clock domain, asynchronous active-low reset
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_channel_defines.svh"

module mem_channel (
    input  logic                          clock_i,
    input  logic                          reset_ni,

    input  logic [`MC_ADDR_W-1:0]         awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`MC_DATA_W-1:0]         wdata,
    input  logic [`MC_DATA_W/8-1:0]       wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output mem_channel_pkg::axi_resp_e    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`MC_ADDR_W-1:0]         araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`MC_DATA_W-1:0]         rdata,
    output mem_channel_pkg::axi_resp_e    rresp,
    output logic                          rvalid,
    input  logic                          rready
);

    // port -> request FIFO -> line store
    logic                         req_push;
    logic                         req_full;
    logic                         req_pop;
    logic                         req_empty;
    mem_channel_pkg::mem_req_t    req_in;
    mem_channel_pkg::mem_req_t    req_out;

    // line store -> response FIFO -> port
    logic                         rsp_push;
    logic                         rsp_full;
    logic                         rsp_pop;
    logic                         rsp_empty;
    mem_channel_pkg::mem_rsp_t    rsp_in;
    mem_channel_pkg::mem_rsp_t    rsp_out;

    axil_slave_port u_port (
        .clock_i   ( clock_i   ),
        .reset_ni  ( reset_ni  ),
        .awaddr    ( awaddr    ),
        .awvalid   ( awvalid   ),
        .awready   ( awready   ),
        .wdata     ( wdata     ),
        .wstrb     ( wstrb     ),
        .wvalid    ( wvalid    ),
        .wready    ( wready    ),
        .bresp     ( bresp     ),
        .bvalid    ( bvalid    ),
        .bready    ( bready    ),
        .araddr    ( araddr    ),
        .arvalid   ( arvalid   ),
        .arready   ( arready   ),
        .rdata     ( rdata     ),
        .rresp     ( rresp     ),
        .rvalid    ( rvalid    ),
        .rready    ( rready    ),
        .req_push  ( req_push  ),
        .req_data  ( req_in    ),
        .req_full  ( req_full  ),
        .rsp_data  ( rsp_out   ),
        .rsp_empty ( rsp_empty ),
        .rsp_pop   ( rsp_pop   )
    );

    sync_fifo #(
        .payload_t ( mem_channel_pkg::mem_req_t ),
        .DEPTH     ( `MC_FIFO_DEPTH             )
    ) u_req_fifo (
        .clock_i   ( clock_i   ),
        .reset_ni  ( reset_ni  ),
        .push      ( req_push  ),
        .push_data ( req_in    ),
        .pop       ( req_pop   ),
        .pop_data  ( req_out   ),
        .full      ( req_full  ),
        .empty     ( req_empty )
    );

    line_store u_store (
        .clock_i   ( clock_i   ),
        .reset_ni  ( reset_ni  ),
        .req_data  ( req_out   ),
        .req_empty ( req_empty ),
        .req_pop   ( req_pop   ),
        .rsp_full  ( rsp_full  ),
        .rsp_push  ( rsp_push  ),
        .rsp_data  ( rsp_in    )
    );

    sync_fifo #(
        .payload_t ( mem_channel_pkg::mem_rsp_t ),
        .DEPTH     ( `MC_FIFO_DEPTH             )
    ) u_rsp_fifo (
        .clock_i   ( clock_i   ),
        .reset_ni  ( reset_ni  ),
        .push      ( rsp_push  ),
        .push_data ( rsp_in    ),
        .pop       ( rsp_pop   ),
        .pop_data  ( rsp_out   ),
        .full      ( rsp_full  ),
        .empty     ( rsp_empty )
    );

endmodule

`default_nettype wire

// File: test/tb_mem_channel.sv
/*
 * testbench for mem_channel, requests are issued and responses collected
 * by two parallel processes so several requests can be in flight
 * expected values come from a word-level model kept while the table is built
 * bready and rready toggle from an LFSR on every falling edge
 * every location is written before it is read
 */
`timescale 1ns/100ps
`default_nettype none

`include "mem_channel_defines.svh"

module tb_mem_channel;

    localparam int TIMEOUT    = 200;                  // cycles allowed per wait
    localparam int WORD_IDX_W = `MC_CHAN_ADDR_W - 2;

    typedef struct packed {
        logic                          is_write;
        logic [`MC_ADDR_W-1:0]         addr;
        logic [`MC_DATA_W-1:0]         data;
        logic [`MC_DATA_W/8-1:0]       strb;
        mem_channel_pkg::axi_resp_e    exp_resp;
        logic [`MC_DATA_W-1:0]         exp_rdata;
    } entry_t;

    logic                          clock_i;
    logic                          reset_ni;
    logic [`MC_ADDR_W-1:0]         awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`MC_DATA_W-1:0]         wdata;
    logic [`MC_DATA_W/8-1:0]       wstrb;
    logic                          wvalid;
    logic                          wready;
    mem_channel_pkg::axi_resp_e    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`MC_ADDR_W-1:0]         araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`MC_DATA_W-1:0]         rdata;
    mem_channel_pkg::axi_resp_e    rresp;
    logic                          rvalid;
    logic                          rready;

    entry_t                  table_q[$];
    logic [`MC_DATA_W-1:0]   shadow [2**WORD_IDX_W];   // expected memory by word
    logic [31:0]             lfsr;
    int                      pass_count;
    int                      fail_count;
    logic                    timed_out;                // set by a wait that gave up

    mem_channel u_mem_channel (
        .clock_i  ( clock_i  ),
        .reset_ni ( reset_ni ),
        .awaddr   ( awaddr   ),
        .awvalid  ( awvalid  ),
        .awready  ( awready  ),
        .wdata    ( wdata    ),
        .wstrb    ( wstrb    ),
        .wvalid   ( wvalid   ),
        .wready   ( wready   ),
        .bresp    ( bresp    ),
        .bvalid   ( bvalid   ),
        .bready   ( bready   ),
        .araddr   ( araddr   ),
        .arvalid  ( arvalid  ),
        .arready  ( arready  ),
        .rdata    ( rdata    ),
        .rresp    ( rresp    ),
        .rvalid   ( rvalid   ),
        .rready   ( rready   )
    );

    initial begin
        clock_i = 1'b0;
        forever #2 clock_i = ~clock_i;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [`MC_DATA_W-1:0] merge_word(input logic [`MC_DATA_W-1:0] old_w,
            input logic [`MC_DATA_W-1:0] new_w, input logic [`MC_DATA_W/8-1:0] strb);
        logic [`MC_DATA_W-1:0] w;
        w = old_w;
        for (int b = 0; b < `MC_DATA_W / 8; b++) begin
            if (strb[b]) w[b*8 +: 8] = new_w[b*8 +: 8];   // strobed bytes only
        end
        return w;
    endfunction

    function automatic logic in_channel(input logic [`MC_ADDR_W-1:0] addr);
        return addr[`MC_ADDR_W-1:`MC_CHAN_ADDR_W] == '0;
    endfunction

    task automatic add_write(input logic [`MC_ADDR_W-1:0] addr,
            input logic [`MC_DATA_W-1:0] data, input logic [`MC_DATA_W/8-1:0] strb);
        entry_t e;
        logic [WORD_IDX_W-1:0] idx;
        idx = addr[`MC_CHAN_ADDR_W-1:2];
        e = '{1'b1, addr, data, strb, mem_channel_pkg::SLVERR, '0};
        if (in_channel(addr)) begin
            e.exp_resp  = mem_channel_pkg::OKAY;
            shadow[idx] = merge_word(shadow[idx], data, strb);
        end
        table_q.push_back(e);
    endtask

    task automatic add_read(input logic [`MC_ADDR_W-1:0] addr);
        entry_t e;
        e = '{1'b0, addr, '0, '0, mem_channel_pkg::SLVERR, '0};   // refused reads give zero
        if (in_channel(addr)) begin
            e.exp_resp  = mem_channel_pkg::OKAY;
            e.exp_rdata = shadow[addr[`MC_CHAN_ADDR_W-1:2]];
        end
        table_q.push_back(e);
    endtask

    task automatic drive_random_ready();
        lfsr   = lfsr_next(lfsr);
        bready = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        rready = lfsr[0];
    endtask

    // raise the valids at a falling edge and hold them until the handshake
    task automatic send_request(input entry_t e, input int n);
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        @(negedge clock_i);
        if (e.is_write) begin
            awaddr  = e.addr;
            wdata   = e.data;
            wstrb   = e.strb;
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end else begin
            araddr  = e.addr;
            arvalid = 1'b1;
        end
        while (!taken && !timed_out) begin
            @(posedge clock_i);
            taken  = e.is_write ? (awready && wready) : arready;
            cycles = cycles + 1;
            if (!taken && cycles >= TIMEOUT) begin
                $display("entry %0d: request was not accepted in time", n);
                timed_out = 1'b1;
            end
            @(negedge clock_i);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
    endtask

    // starts and ends on a falling edge
    task automatic collect_response(input int n, output logic on_b,
            output mem_channel_pkg::axi_resp_e resp, output logic [`MC_DATA_W-1:0] data);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        on_b   = 1'b0;
        resp   = mem_channel_pkg::OKAY;
        data   = '0;
        while (!got && !timed_out) begin
            drive_random_ready();
            @(posedge clock_i);
            if (bvalid && bready) begin
                got  = 1'b1;
                on_b = 1'b1;
                resp = bresp;
                data = '0;
            end else if (rvalid && rready) begin
                got  = 1'b1;
                on_b = 1'b0;
                resp = rresp;
                data = rdata;
            end
            cycles = cycles + 1;
            if (!got && cycles >= TIMEOUT) begin
                $display("entry %0d: no response arrived in time", n);
                timed_out = 1'b1;
            end
            @(negedge clock_i);
        end
    endtask

    // responses must come back in table order
    task automatic check_response(input int n);
        entry_t                        e;
        int                            errs;
        logic                          on_b;
        mem_channel_pkg::axi_resp_e    resp;
        logic [`MC_DATA_W-1:0]         data;
        e    = table_q[n];
        errs = 0;
        collect_response(n, on_b, resp, data);
        if (timed_out) begin
            fail_count = fail_count + 1;
            return;
        end
        if (on_b !== e.is_write) begin
            $display("entry %0d: the response came back on the wrong channel", n);
            errs = errs + 1;
        end
        if (resp !== e.exp_resp) begin
            $display("Error at %0t: %s expected %0d got %0d", $time,
                     e.is_write ? "bresp" : "rresp", e.exp_resp, resp);
            errs = errs + 1;
        end
        if (!e.is_write && data !== e.exp_rdata) begin
            $display("Error at %0t: rdata expected %h got %h", $time, e.exp_rdata, data);
            errs = errs + 1;
        end
        $display("entry %0d %s %h: %s", n, e.is_write ? "write" : "read", e.addr,
                 (errs == 0) ? "ok" : "FAILED");
        if (errs == 0) pass_count = pass_count + 1;
        else fail_count = fail_count + 1;
    endtask

    initial begin
        reset_ni = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        lfsr     = 32'h8aa8_9544;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;

        // four lanes of line 5 then read back
        for (int k = 0; k < 4; k++) begin
            add_write(32'h50 + 32'(k * 4), 32'h1111_1111 * 32'(k + 1), 4'hf);
        end
        for (int k = 0; k < 4; k++) begin
            add_read(32'h50 + 32'(k * 4));
        end
        // byte merge
        add_write(32'h60, 32'hdead_beef, 4'hf);
        add_write(32'h60, 32'h1234_5678, 4'b0101);
        add_read(32'h60);
        // out of range addresses 0x460 and 0x8000_0060 both alias 0x60
        add_write(32'h0000_0460, 32'hffff_ffff, 4'hf);
        add_read(32'h8000_0060);
        add_read(32'h60);
        // interleaved traffic over lines 10 to 17
        for (int i = 0; i < 8; i++) begin
            add_write(32'((10 + i) * 16 + (i % 4) * 4), 32'hc0de_0000 + 32'(i * 257), 4'hf);
            if (i > 0) add_read(32'((9 + i) * 16 + ((i - 1) % 4) * 4));
        end
        add_read(32'(17 * 16 + 3 * 4));

        repeat (16) @(posedge clock_i);
        @(negedge clock_i);
        reset_ni = 1'b1;
        repeat (2) @(negedge clock_i);
        if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
            $display("Error at %0t: bvalid/rvalid expected 0/0 got %b/%b", $time, bvalid, rvalid);
            fail_count = fail_count + 1;
        end else begin
            $display("reset: ok");
            pass_count = pass_count + 1;
        end

        fork
            begin
                for (int n = 0; n < table_q.size() && !timed_out; n++) begin
                    send_request(table_q[n], n);
                end
            end
            begin
                for (int n = 0; n < table_q.size() && !timed_out; n++) begin
                    check_response(n);
                end
            end
        join

        $display("passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/mem_channel_pkg.sv
hw/sync_fifo.sv
hw/axil_slave_port.sv
hw/line_store.sv
hw/mem_channel.sv
test/tb_mem_channel.sv

// File: run.sh
#!/bin/sh
# build and run tb_mem_channel with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing -f project.f --top-module tb_mem_channel -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log
grep -qx "Test passed" sim.log 2>/dev/null && exit 0 || exit 1
